// File: dcache.f
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_array.sv
hw/dcache_lrq.sv
hw/dcache_refill.sv
hw/dcache_perf_counters.sv
hw/dcache_top.sv
tb/dcache_tb.sv

// File: hw/dcache_array.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_array #(
  localparam int OFF_W  = $clog2(`DC_LINE_B),
  localparam int IDX_W  = $clog2(`DC_SETS),
  localparam int TAG_W  = `DC_PADDR_W - OFF_W - IDX_W,
  localparam int WAY_W  = $clog2(`DC_WAYS),
  localparam int DATA_W = `DC_LINE_B * 8
) (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic [`DC_RD_PORTS-1:0]  i_rd_valid,
  input  logic [`DC_PADDR_W-1:0]   i_rd_paddr [`DC_RD_PORTS],
  input  logic                     i_upd_valid,
  input  logic [`DC_PADDR_W-1:0]   i_upd_paddr,
  input  logic [WAY_W-1:0]         i_upd_way,
  input  logic [`DC_LINE_B-1:0]    i_upd_be,
  input  logic [DATA_W-1:0]        i_upd_data,
  input  logic                     i_upd_fill,
  output logic [`DC_RD_PORTS-1:0]  o_rd_hit,
  output logic [`DC_RD_PORTS-1:0]  o_rd_miss,
  output logic [`DC_RD_PORTS-1:0]  o_rd_conflict,
  output logic [DATA_W-1:0]        o_rd_data [`DC_RD_PORTS],
  output logic [WAY_W-1:0]         o_rd_victim_way [`DC_RD_PORTS],
  output logic [`DC_PADDR_W-1:0]   o_rd_s1_paddr [`DC_RD_PORTS]
);

  logic [TAG_W-1:0]    r_tag  [`DC_SETS][`DC_WAYS];
  logic [DATA_W-1:0]   r_data [`DC_SETS][`DC_WAYS];
  logic [`DC_WAYS-1:0] r_valid [`DC_SETS];
  logic [WAY_W-1:0]    r_rr [`DC_SETS];   // next victim per set

  logic [`DC_RD_PORTS-1:0] r_s1_valid;
  logic [`DC_PADDR_W-1:0]  r_s1_paddr [`DC_RD_PORTS];
  logic [IDX_W-1:0]        w_upd_idx;

  assign w_upd_idx = i_upd_paddr[OFF_W +: IDX_W];

  // ----------------------------------------
  // s0 -> s1 request registers
  // ----------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= '0;
    end else begin
      r_s1_valid <= i_rd_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    for (int p = 0; p < `DC_RD_PORTS; p++) begin
      if (i_rd_valid[p]) begin
        r_s1_paddr[p] <= i_rd_paddr[p];
      end
    end
  end

  // ----------------------------------------
  // s1 tag compare per port
  // ----------------------------------------
  for (genvar p = 0; p < `DC_RD_PORTS; p++) begin : g_port
    logic [IDX_W-1:0]    w_idx;
    logic [TAG_W-1:0]    w_tag;
    logic [`DC_WAYS-1:0] w_way_hit;
    logic [DATA_W-1:0]   w_data;
    logic                w_conflict;

    assign w_idx      = r_s1_paddr[p][OFF_W +: IDX_W];
    assign w_tag      = r_s1_paddr[p][`DC_PADDR_W-1 -: TAG_W];
    assign w_conflict = i_upd_valid & (w_upd_idx == w_idx);   // set busy with a write

    always_comb begin
      w_data = '0;
      for (int w = 0; w < `DC_WAYS; w++) begin
        w_way_hit[w] = r_valid[w_idx][w] & (r_tag[w_idx][w] == w_tag);
        if (w_way_hit[w]) begin
          w_data = w_data | r_data[w_idx][w];   // at most one way hits
        end
      end
    end

    assign o_rd_hit[p]        = r_s1_valid[p] & ~w_conflict & (|w_way_hit);
    assign o_rd_miss[p]       = r_s1_valid[p] & ~w_conflict & ~(|w_way_hit);
    assign o_rd_conflict[p]   = r_s1_valid[p] & w_conflict;
    assign o_rd_data[p]       = w_data;
    assign o_rd_victim_way[p] = r_rr[w_idx];
    assign o_rd_s1_paddr[p]   = r_s1_paddr[p];

    // a line sits in at most one way of its set
    a_way_hit_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      r_s1_valid[p] |-> $onehot0(w_way_hit));
  end

  // ----------------------------------------
  // update write
  // ----------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int s = 0; s < `DC_SETS; s++) begin
        r_valid[s] <= '0;
        r_rr[s]    <= '0;
      end
    end else if (i_upd_valid && i_upd_fill) begin
      r_valid[w_upd_idx][i_upd_way] <= 1'b1;
      r_rr[w_upd_idx]               <= i_upd_way + 1'b1;   // move past the filled way
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_upd_valid) begin
      for (int b = 0; b < `DC_LINE_B; b++) begin
        if (i_upd_be[b]) begin
          r_data[w_upd_idx][i_upd_way][b*8 +: 8] <= i_upd_data[b*8 +: 8];
        end
      end
      if (i_upd_fill) begin
        r_tag[w_upd_idx][i_upd_way] <= i_upd_paddr[`DC_PADDR_W-1 -: TAG_W];
      end
    end
  end

  a_fill_full_line: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_upd_valid && i_upd_fill) |-> (&i_upd_be));

endmodule

`default_nettype wire

// File: hw/dcache_lrq.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_lrq #(
  localparam int OFF_W = $clog2(`DC_LINE_B),
  localparam int WAY_W = $clog2(`DC_WAYS),
  localparam int LRQ_W = $clog2(`DC_LRQ_N)
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic [`DC_RD_PORTS-1:0] i_miss_valid,
  input  logic [`DC_PADDR_W-1:0]  i_miss_paddr [`DC_RD_PORTS],
  input  logic [WAY_W-1:0]        i_miss_way [`DC_RD_PORTS],
  output logic                    o_l2_req_valid,
  output logic [`DC_PADDR_W-1:0]  o_l2_req_paddr,
  output dcache_pkg::l2_tag_u     o_l2_req_tag,
  input  logic                    i_search_valid,
  input  logic [LRQ_W-1:0]        i_search_idx,
  output logic [`DC_PADDR_W-1:0]  o_search_paddr,
  output logic [WAY_W-1:0]        o_search_way,
  input  logic                    i_release_valid
);

  dcache_pkg::lrq_state_e r_state [`DC_LRQ_N];
  logic [`DC_PADDR_W-1:0] r_paddr [`DC_LRQ_N];   // line aligned
  logic [WAY_W-1:0]       r_way [`DC_LRQ_N];
  logic [LRQ_W-1:0]       r_rel_idx;             // entry of the last search

  logic                   w_alloc;
  logic [LRQ_W-1:0]       w_free_idx;
  logic [`DC_PADDR_W-1:0] w_alloc_paddr;
  logic [WAY_W-1:0]       w_alloc_way;
  logic                   w_issue;
  logic [LRQ_W-1:0]       w_issue_idx;

  // ----------------------------------------
  // pick lowest miss, free entry and issue entry
  // ----------------------------------------
  always_comb begin
    logic miss_found;
    logic free_found;
    logic dup;
    miss_found    = 1'b0;
    free_found    = 1'b0;
    dup           = 1'b0;
    w_alloc_paddr = '0;
    w_alloc_way   = '0;
    w_free_idx    = '0;
    w_issue       = 1'b0;
    w_issue_idx   = '0;
    for (int p = `DC_RD_PORTS-1; p >= 0; p--) begin   // last write wins so lowest port is kept
      if (i_miss_valid[p]) begin
        miss_found    = 1'b1;
        w_alloc_paddr = {i_miss_paddr[p][`DC_PADDR_W-1:OFF_W], {OFF_W{1'b0}}};
        w_alloc_way   = i_miss_way[p];
      end
    end
    for (int e = `DC_LRQ_N-1; e >= 0; e--) begin
      if (r_state[e] == dcache_pkg::LRQ_FREE) begin
        free_found = 1'b1;
        w_free_idx = LRQ_W'(e);
      end else if (r_paddr[e] == w_alloc_paddr) begin
        dup = 1'b1;   // line already on its way
      end
      if (r_state[e] == dcache_pkg::LRQ_ISSUE) begin
        w_issue     = 1'b1;
        w_issue_idx = LRQ_W'(e);
      end
    end
    w_alloc = miss_found & free_found & ~dup;
  end

  always_comb begin
    o_l2_req_tag = '0;
    o_l2_req_tag.rd.kind = dcache_pkg::L2_KIND_RD_L1D;
    o_l2_req_tag.rd.lrq_idx[LRQ_W-1:0] = w_issue_idx;
  end

  assign o_l2_req_valid = w_issue;
  assign o_l2_req_paddr = r_paddr[w_issue_idx];
  assign o_search_paddr = r_paddr[i_search_idx];
  assign o_search_way   = r_way[i_search_idx];

  // ----------------------------------------
  // entry state machines
  // ----------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int e = 0; e < `DC_LRQ_N; e++) begin
        r_state[e] <= dcache_pkg::LRQ_FREE;
      end
      r_rel_idx <= '0;
    end else begin
      for (int e = 0; e < `DC_LRQ_N; e++) begin
        if (w_alloc && (w_free_idx == LRQ_W'(e))) begin
          r_state[e] <= dcache_pkg::LRQ_ISSUE;
        end else if (w_issue && (w_issue_idx == LRQ_W'(e))) begin
          r_state[e] <= dcache_pkg::LRQ_WAIT;
        end else if (i_release_valid && (r_rel_idx == LRQ_W'(e))) begin
          r_state[e] <= dcache_pkg::LRQ_FREE;
        end
      end
      if (i_search_valid) begin
        r_rel_idx <= i_search_idx;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_alloc) begin
      r_paddr[w_free_idx] <= w_alloc_paddr;
      r_way[w_free_idx]   <= w_alloc_way;
    end
  end

  a_search_wait: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_search_valid |-> (r_state[i_search_idx] == dcache_pkg::LRQ_WAIT));

  // only a waiting entry gets released
  a_release_wait: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_release_valid |-> (r_state[r_rel_idx] == dcache_pkg::LRQ_WAIT));

endmodule

`default_nettype wire

// File: hw/dcache_perf_counters.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_perf_counters (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic [`DC_RD_PORTS-1:0] i_s1_hit,
  input  logic [`DC_RD_PORTS-1:0] i_s1_miss,
  input  logic [`DC_RD_PORTS-1:0] i_s1_conflict,
  input  logic                    i_perf_snap,
  output logic [`DC_PERF_W-1:0]   o_perf_reqs,
  output logic [`DC_PERF_W-1:0]   o_perf_hits,
  output logic [`DC_PERF_W-1:0]   o_perf_misses,
  output logic [`DC_PERF_W-1:0]   o_perf_conflicts
);

  logic [`DC_PERF_W-1:0]   r_cnt  [4];   // reqs, hits, misses, conflicts
  logic [`DC_PERF_W-1:0]   r_snap [4];
  logic [`DC_RD_PORTS-1:0] w_ev   [4];

  // add this cycle's port events, stick at all ones
  function automatic logic [`DC_PERF_W-1:0] sat_add(input logic [`DC_PERF_W-1:0] cnt,
                                                    input logic [`DC_RD_PORTS-1:0] ev);
    logic [`DC_PERF_W:0] sum;
    sum = {1'b0, cnt};
    for (int p = 0; p < `DC_RD_PORTS; p++) begin
      sum = sum + ev[p];
    end
    return sum[`DC_PERF_W] ? {`DC_PERF_W{1'b1}} : sum[`DC_PERF_W-1:0];
  endfunction

  assign w_ev[0] = i_s1_hit | i_s1_miss | i_s1_conflict;
  assign w_ev[1] = i_s1_hit;
  assign w_ev[2] = i_s1_miss;
  assign w_ev[3] = i_s1_conflict;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int k = 0; k < 4; k++) begin
        r_cnt[k]  <= '0;
        r_snap[k] <= '0;
      end
    end else begin
      for (int k = 0; k < 4; k++) begin
        if (i_perf_snap) begin
          r_snap[k] <= sat_add(r_cnt[k], w_ev[k]);   // snap cycle still counts
          r_cnt[k]  <= '0;
        end else begin
          r_cnt[k] <= sat_add(r_cnt[k], w_ev[k]);
        end
      end
    end
  end

  assign o_perf_reqs      = r_snap[0];
  assign o_perf_hits      = r_snap[1];
  assign o_perf_misses    = r_snap[2];
  assign o_perf_conflicts = r_snap[3];

endmodule

`default_nettype wire

// File: hw/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  // kind field shared by both tag views
  localparam logic [1:0] L2_KIND_RD_L1D = 2'b01;

  typedef struct packed {
    logic [1:0] kind;
    logic [3:0] lrq_idx;   // refill queue entry
  } l2_tag_l1d_t;

  typedef struct packed {
    logic [1:0] kind;
    logic [3:0] src_id;    // some other L2 client
  } l2_tag_fgn_t;

  // one 6-bit tag word, view chosen by kind
  typedef union packed {
    l2_tag_l1d_t rd;
    l2_tag_fgn_t fgn;
  } l2_tag_u;

  typedef enum logic [1:0] {
    LRQ_FREE,
    LRQ_ISSUE,   // waiting for the L2 request slot
    LRQ_WAIT     // request sent, response pending
  } lrq_state_e;

endpackage

`default_nettype wire

// File: hw/dcache_refill.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_refill #(
  localparam int WAY_W  = $clog2(`DC_WAYS),
  localparam int LRQ_W  = $clog2(`DC_LRQ_N),
  localparam int DATA_W = `DC_LINE_B * 8
) (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_l2_resp_valid,
  input  dcache_pkg::l2_tag_u    i_l2_resp_tag,
  input  logic [DATA_W-1:0]      i_l2_resp_data,
  output logic                   o_search_valid,
  output logic [LRQ_W-1:0]       o_search_idx,
  input  logic [`DC_PADDR_W-1:0] i_search_paddr,
  input  logic [WAY_W-1:0]       i_search_way,
  output logic                   o_release_valid,
  input  logic                   i_st_merge_valid,
  input  logic [`DC_LINE_B-1:0]  i_st_merge_be,
  input  logic [DATA_W-1:0]      i_st_merge_data,
  input  logic                   i_st_valid,
  input  logic [`DC_PADDR_W-1:0] i_st_paddr,
  input  logic [WAY_W-1:0]       i_st_way,
  input  logic [`DC_LINE_B-1:0]  i_st_be,
  input  logic [DATA_W-1:0]      i_st_data,
  output logic                   o_st_conflict,
  output logic                   o_upd_valid,
  output logic [`DC_PADDR_W-1:0] o_upd_paddr,
  output logic [WAY_W-1:0]       o_upd_way,
  output logic [`DC_LINE_B-1:0]  o_upd_be,
  output logic [DATA_W-1:0]      o_upd_data,
  output logic                   o_upd_fill
);

  logic                   r_rp1_valid;
  logic [LRQ_W-1:0]       r_rp1_idx;
  logic [DATA_W-1:0]      r_rp1_data;
  logic                   r_rp2_valid;
  logic [`DC_PADDR_W-1:0] r_rp2_paddr;
  logic [WAY_W-1:0]       r_rp2_way;
  logic [DATA_W-1:0]      r_rp2_data;
  logic [DATA_W-1:0]      w_merged;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rp1_valid <= 1'b0;
      r_rp2_valid <= 1'b0;
    end else begin
      // foreign kinds are not ours, drop them here
      r_rp1_valid <= i_l2_resp_valid & (i_l2_resp_tag.rd.kind == dcache_pkg::L2_KIND_RD_L1D);
      r_rp2_valid <= r_rp1_valid;
    end
  end

  // ----------------------------------------
  // RP1 capture, RP2 with searched entry
  // ----------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_l2_resp_valid) begin
      r_rp1_idx  <= i_l2_resp_tag.rd.lrq_idx[LRQ_W-1:0];
      r_rp1_data <= i_l2_resp_data;
    end
    if (r_rp1_valid) begin
      r_rp2_paddr <= i_search_paddr;
      r_rp2_way   <= i_search_way;
      r_rp2_data  <= r_rp1_data;
    end
  end

  assign o_search_valid  = r_rp1_valid;
  assign o_search_idx    = r_rp1_idx;
  assign o_release_valid = r_rp2_valid;   // line written this cycle

  for (genvar b = 0; b < `DC_LINE_B; b++) begin : g_merge
    assign w_merged[b*8 +: 8] = (i_st_merge_valid & i_st_merge_be[b]) ?
                                i_st_merge_data[b*8 +: 8] : r_rp2_data[b*8 +: 8];
  end

  // ----------------------------------------
  // update select, refill beats store
  // ----------------------------------------
  assign o_upd_valid   = r_rp2_valid | i_st_valid;
  assign o_upd_fill    = r_rp2_valid;
  assign o_upd_paddr   = r_rp2_valid ? r_rp2_paddr : i_st_paddr;
  assign o_upd_way     = r_rp2_valid ? r_rp2_way : i_st_way;
  assign o_upd_be      = r_rp2_valid ? {`DC_LINE_B{1'b1}} : i_st_be;
  assign o_upd_data    = r_rp2_valid ? w_merged : i_st_data;
  assign o_st_conflict = r_rp2_valid & i_st_valid;   // store dropped, requester retries

  a_merge_in_rp2: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_st_merge_valid |-> r_rp2_valid);

endmodule

`default_nettype wire

// File: hw/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// ----------------------------------------
// cache geometry
// ----------------------------------------
`define DC_WAYS     2
`define DC_SETS     16
`define DC_LINE_B   16   // bytes per line
`define DC_PADDR_W  32

// ----------------------------------------
// load/store unit side
// ----------------------------------------
`define DC_LRQ_N    4    // refill queue depth
`define DC_RD_PORTS 2
`define DC_PERF_W   16

`endif

// File: hw/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_top #(
  localparam int WAY_W  = $clog2(`DC_WAYS),
  localparam int LRQ_W  = $clog2(`DC_LRQ_N),
  localparam int DATA_W = `DC_LINE_B * 8
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  // read ports
  input  logic [`DC_RD_PORTS-1:0] i_rd_valid,
  input  logic [`DC_PADDR_W-1:0]  i_rd_paddr [`DC_RD_PORTS],
  output logic [`DC_RD_PORTS-1:0] o_rd_hit,
  output logic [`DC_RD_PORTS-1:0] o_rd_miss,
  output logic [`DC_RD_PORTS-1:0] o_rd_conflict,
  output logic [DATA_W-1:0]       o_rd_data [`DC_RD_PORTS],
  // L2 side
  output logic                    o_l2_req_valid,
  output logic [`DC_PADDR_W-1:0]  o_l2_req_paddr,
  output dcache_pkg::l2_tag_u     o_l2_req_tag,
  input  logic                    i_l2_resp_valid,
  input  dcache_pkg::l2_tag_u     i_l2_resp_tag,
  input  logic [DATA_W-1:0]       i_l2_resp_data,
  // store and merge
  input  logic                    i_st_valid,
  input  logic [`DC_PADDR_W-1:0]  i_st_paddr,
  input  logic [WAY_W-1:0]        i_st_way,
  input  logic [`DC_LINE_B-1:0]   i_st_be,
  input  logic [DATA_W-1:0]       i_st_data,
  output logic                    o_st_conflict,
  input  logic                    i_st_merge_valid,
  input  logic [`DC_LINE_B-1:0]   i_st_merge_be,
  input  logic [DATA_W-1:0]       i_st_merge_data,
  // perf
  input  logic                    i_perf_snap,
  output logic [`DC_PERF_W-1:0]   o_perf_reqs,
  output logic [`DC_PERF_W-1:0]   o_perf_hits,
  output logic [`DC_PERF_W-1:0]   o_perf_misses,
  output logic [`DC_PERF_W-1:0]   o_perf_conflicts
);

  logic [WAY_W-1:0]       w_victim_way [`DC_RD_PORTS];
  logic [`DC_PADDR_W-1:0] w_s1_paddr [`DC_RD_PORTS];
  logic                   w_upd_valid;
  logic [`DC_PADDR_W-1:0] w_upd_paddr;
  logic [WAY_W-1:0]       w_upd_way;
  logic [`DC_LINE_B-1:0]  w_upd_be;
  logic [DATA_W-1:0]      w_upd_data;
  logic                   w_upd_fill;
  logic                   w_search_valid;
  logic [LRQ_W-1:0]       w_search_idx;
  logic [`DC_PADDR_W-1:0] w_search_paddr;
  logic [WAY_W-1:0]       w_search_way;
  logic                   w_release_valid;

  dcache_array u_array (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_rd_valid(i_rd_valid), .i_rd_paddr(i_rd_paddr),
    .i_upd_valid(w_upd_valid), .i_upd_paddr(w_upd_paddr), .i_upd_way(w_upd_way),
    .i_upd_be(w_upd_be), .i_upd_data(w_upd_data), .i_upd_fill(w_upd_fill),
    .o_rd_hit(o_rd_hit), .o_rd_miss(o_rd_miss), .o_rd_conflict(o_rd_conflict),
    .o_rd_data(o_rd_data), .o_rd_victim_way(w_victim_way), .o_rd_s1_paddr(w_s1_paddr)
  );

  dcache_lrq u_lrq (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_miss_valid(o_rd_miss), .i_miss_paddr(w_s1_paddr), .i_miss_way(w_victim_way),
    .o_l2_req_valid(o_l2_req_valid), .o_l2_req_paddr(o_l2_req_paddr),
    .o_l2_req_tag(o_l2_req_tag),
    .i_search_valid(w_search_valid), .i_search_idx(w_search_idx),
    .o_search_paddr(w_search_paddr), .o_search_way(w_search_way),
    .i_release_valid(w_release_valid)
  );

  dcache_refill u_refill (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_l2_resp_valid(i_l2_resp_valid), .i_l2_resp_tag(i_l2_resp_tag),
    .i_l2_resp_data(i_l2_resp_data),
    .o_search_valid(w_search_valid), .o_search_idx(w_search_idx),
    .i_search_paddr(w_search_paddr), .i_search_way(w_search_way),
    .o_release_valid(w_release_valid),
    .i_st_merge_valid(i_st_merge_valid), .i_st_merge_be(i_st_merge_be),
    .i_st_merge_data(i_st_merge_data),
    .i_st_valid(i_st_valid), .i_st_paddr(i_st_paddr), .i_st_way(i_st_way),
    .i_st_be(i_st_be), .i_st_data(i_st_data), .o_st_conflict(o_st_conflict),
    .o_upd_valid(w_upd_valid), .o_upd_paddr(w_upd_paddr), .o_upd_way(w_upd_way),
    .o_upd_be(w_upd_be), .o_upd_data(w_upd_data), .o_upd_fill(w_upd_fill)
  );

  dcache_perf_counters u_perf (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_s1_hit(o_rd_hit), .i_s1_miss(o_rd_miss), .i_s1_conflict(o_rd_conflict),
    .i_perf_snap(i_perf_snap),
    .o_perf_reqs(o_perf_reqs), .o_perf_hits(o_perf_hits),
    .o_perf_misses(o_perf_misses), .o_perf_conflicts(o_perf_conflicts)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f dcache.f
out=$(./obj_dir/Vdcache_tb 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
  exit 0
fi
exit 1

// File: tb/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_tb;

  localparam int DATA_W    = `DC_LINE_B * 8;
  localparam int WAY_W     = $clog2(`DC_WAYS);
  localparam int MAX_STEPS = 64;

  logic                    i_clk;
  logic                    i_reset_n;
  logic [`DC_RD_PORTS-1:0] i_rd_valid;
  logic [`DC_PADDR_W-1:0]  i_rd_paddr [`DC_RD_PORTS];
  logic [`DC_RD_PORTS-1:0] o_rd_hit;
  logic [`DC_RD_PORTS-1:0] o_rd_miss;
  logic [`DC_RD_PORTS-1:0] o_rd_conflict;
  logic [DATA_W-1:0]       o_rd_data [`DC_RD_PORTS];
  logic                    o_l2_req_valid;
  logic [`DC_PADDR_W-1:0]  o_l2_req_paddr;
  dcache_pkg::l2_tag_u     o_l2_req_tag;
  logic                    i_l2_resp_valid;
  dcache_pkg::l2_tag_u     i_l2_resp_tag;
  logic [DATA_W-1:0]       i_l2_resp_data;
  logic                    i_st_valid;
  logic [`DC_PADDR_W-1:0]  i_st_paddr;
  logic [WAY_W-1:0]        i_st_way;
  logic [`DC_LINE_B-1:0]   i_st_be;
  logic [DATA_W-1:0]       i_st_data;
  logic                    o_st_conflict;
  logic                    i_st_merge_valid;
  logic [`DC_LINE_B-1:0]   i_st_merge_be;
  logic [DATA_W-1:0]       i_st_merge_data;
  logic                    i_perf_snap;
  logic [`DC_PERF_W-1:0]   o_perf_reqs;
  logic [`DC_PERF_W-1:0]   o_perf_hits;
  logic [`DC_PERF_W-1:0]   o_perf_misses;
  logic [`DC_PERF_W-1:0]   o_perf_conflicts;

  // trace steps, one entry per data line
  logic [8*24-1:0]        t_name [MAX_STEPS];
  logic [8*8-1:0]         t_op   [MAX_STEPS];
  logic [`DC_PADDR_W-1:0] t_addr [MAX_STEPS];
  logic [7:0]             t_x    [MAX_STEPS];   // port, way or tag
  logic [`DC_LINE_B-1:0]  t_mask [MAX_STEPS];
  logic [DATA_W-1:0]      t_d1   [MAX_STEPS];
  logic [DATA_W-1:0]      t_d2   [MAX_STEPS];
  logic [3:0]             t_exp  [MAX_STEPS];
  int                     n_steps;

  logic [`DC_PADDR_W-1:0] req_paddr_q [$];   // l2 requests seen, oldest first
  logic [5:0]             req_tag_q [$];

  logic [8*24-1:0] cur_name;
  int n_cycles = 0;
  int cycle_limit = 0;
  int n_checks = 0;
  int n_errors = 0;
  int n_tests = 0;
  int n_failed = 0;
  int test_checks = 0;
  int test_errors = 0;
  int cnt_reqs = 0;
  int cnt_hits = 0;
  int cnt_misses = 0;
  int cnt_conflicts = 0;

  dcache_top dut_i (.*);

  always #20 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    n_cycles <= n_cycles + 1;
    if (cycle_limit != 0 && n_cycles >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles", n_cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  always @(negedge i_clk) begin
    if (i_reset_n && o_l2_req_valid) begin
      req_paddr_q.push_back(o_l2_req_paddr);
      req_tag_q.push_back(o_l2_req_tag);
    end
  end

  // ----------------------------------------
  // checking and trace loading
  // ----------------------------------------
  task automatic compare(input string field, input logic [DATA_W-1:0] exp,
                         input logic [DATA_W-1:0] act);
    n_checks++;
    test_checks++;
    if (exp !== act) begin
      n_errors++;
      test_errors++;
      $display("error %0s %0s: expected %h, actual %h", cur_name, field, exp, act);
    end
  endtask

  task automatic load_trace();
    int fd;
    int cnt;
    logic [8*256-1:0]       line;
    logic [8*24-1:0]        name;
    logic [8*8-1:0]         op;
    logic [`DC_PADDR_W-1:0] addr;
    logic [7:0]             x;
    logic [`DC_LINE_B-1:0]  mask;
    logic [DATA_W-1:0]      d1;
    logic [DATA_W-1:0]      d2;
    logic [3:0]             exp;
    n_steps = 0;
    fd = $fopen("tb/dcache_trace.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd) && n_steps < MAX_STEPS) begin
        line = '0;
        cnt = $fgets(line, fd);
        cnt = $sscanf(line, "%s %s %h %h %h %h %h %h", name, op, addr, x, mask, d1, d2, exp);
        if (cnt == 8 && name != "#") begin   // header lines fall out here
          t_name[n_steps] = name;
          t_op[n_steps]   = op;
          t_addr[n_steps] = addr;
          t_x[n_steps]    = x;
          t_mask[n_steps] = mask;
          t_d1[n_steps]   = d1;
          t_d2[n_steps]   = d2;
          t_exp[n_steps]  = exp;
          n_steps++;
        end
      end
      $fclose(fd);
    end
  endtask

  // outcome is one-hot {conflict, hit, miss}
  task automatic check_read(input int p, input logic [3:0] exp, input logic [DATA_W-1:0] data);
    compare("read outcome", DATA_W'(exp), DATA_W'({o_rd_conflict[p], o_rd_hit[p], o_rd_miss[p]}));
    if (exp == 4'h2) begin
      compare("read data", data, o_rd_data[p]);
    end
    cnt_reqs++;
    cnt_hits      += (exp == 4'h2) ? 1 : 0;
    cnt_misses    += (exp == 4'h1) ? 1 : 0;
    cnt_conflicts += (exp == 4'h4) ? 1 : 0;
  endtask

  // ----------------------------------------
  // trace operations
  // ----------------------------------------
  task automatic drive_read(input int i);
    int p;
    p = int'(t_x[i]);
    @(posedge i_clk);
    i_rd_valid[p] <= 1'b1;
    i_rd_paddr[p] <= t_addr[i];
    @(posedge i_clk);
    i_rd_valid <= '0;
    @(negedge i_clk);   // s1 result
    check_read(p, t_exp[i], t_d1[i]);
  endtask

  task automatic drive_store(input int i);
    @(posedge i_clk);
    i_st_valid <= 1'b1;
    i_st_paddr <= t_addr[i];
    i_st_way   <= WAY_W'(t_x[i]);
    i_st_be    <= t_mask[i];
    i_st_data  <= t_d1[i];
    @(negedge i_clk);
    compare("store conflict", DATA_W'(t_exp[i]), DATA_W'(o_st_conflict));
    @(posedge i_clk);
    i_st_valid <= 1'b0;
  endtask

  // rsp plain, mrsp adds merge and a colliding store, rspc adds a read into RP2
  task automatic respond(input int i);
    dcache_pkg::l2_tag_u    tag;
    logic [`DC_PADDR_W-1:0] req_paddr;
    logic [5:0]             req_tag;
    tag = t_x[i][5:0];
    if (tag.rd.kind == dcache_pkg::L2_KIND_RD_L1D) begin
      while (req_paddr_q.size() == 0) begin
        @(negedge i_clk);
      end
      req_paddr = req_paddr_q.pop_front();
      req_tag   = req_tag_q.pop_front();
      compare("l2 request paddr", t_addr[i], req_paddr);
      compare("l2 request tag", DATA_W'(tag), DATA_W'(req_tag));
    end
    @(posedge i_clk);
    i_l2_resp_valid <= 1'b1;
    i_l2_resp_tag   <= tag;
    i_l2_resp_data  <= t_d1[i];
    @(posedge i_clk);   // RP1
    i_l2_resp_valid <= 1'b0;
    if (t_op[i] == "rspc") begin
      i_rd_valid[0] <= 1'b1;
      i_rd_paddr[0] <= t_addr[i];
    end
    @(posedge i_clk);   // RP2, update active
    i_rd_valid <= '0;
    if (t_op[i] == "mrsp") begin
      i_st_merge_valid <= 1'b1;
      i_st_merge_be    <= t_mask[i];
      i_st_merge_data  <= t_d2[i];
      i_st_valid       <= 1'b1;
      i_st_paddr       <= t_addr[i];
      i_st_way         <= '0;
      i_st_be          <= '1;
      i_st_data        <= ~t_d2[i];
    end
    @(negedge i_clk);
    if (t_op[i] == "rspc") begin
      check_read(0, t_exp[i], '0);
    end
    if (t_op[i] == "mrsp") begin
      compare("store conflict", DATA_W'(t_exp[i]), DATA_W'(o_st_conflict));
    end
    @(posedge i_clk);
    i_st_merge_valid <= 1'b0;
    i_st_valid       <= 1'b0;
  endtask

  task automatic take_snapshot();
    @(posedge i_clk);
    i_perf_snap <= 1'b1;
    @(posedge i_clk);
    i_perf_snap <= 1'b0;
    @(negedge i_clk);
    compare("perf reqs", DATA_W'(cnt_reqs), DATA_W'(o_perf_reqs));
    compare("perf hits", DATA_W'(cnt_hits), DATA_W'(o_perf_hits));
    compare("perf misses", DATA_W'(cnt_misses), DATA_W'(o_perf_misses));
    compare("perf conflicts", DATA_W'(cnt_conflicts), DATA_W'(o_perf_conflicts));
    cnt_reqs      = 0;
    cnt_hits      = 0;
    cnt_misses    = 0;
    cnt_conflicts = 0;
  endtask

  task automatic run_step(input int i);
    if (t_op[i] == "rd") begin
      drive_read(i);
    end else if (t_op[i] == "st") begin
      drive_store(i);
    end else if (t_op[i] == "rsp" || t_op[i] == "mrsp" || t_op[i] == "rspc") begin
      respond(i);
    end else if (t_op[i] == "snap") begin
      take_snapshot();
    end else begin
      n_errors++;
      test_errors++;
      $display("test %0s step %0d has an unknown operation %0s", cur_name, i, t_op[i]);
    end
  endtask

  task automatic close_test();
    n_tests++;
    if (test_errors == 0) begin
      $display("test %0s: passed, %0d checks", cur_name, test_checks);
    end else begin
      n_failed++;
      $display("test %0s: failed, %0d of %0d checks wrong", cur_name, test_errors, test_checks);
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    i_clk            = 1'b0;
    i_reset_n        = 1'b0;
    i_rd_valid       = '0;
    for (int p = 0; p < `DC_RD_PORTS; p++) begin
      i_rd_paddr[p] = '0;
    end
    i_l2_resp_valid  = 1'b0;
    i_l2_resp_tag    = '0;
    i_l2_resp_data   = '0;
    i_st_valid       = 1'b0;
    i_st_paddr       = '0;
    i_st_way         = '0;
    i_st_be          = '0;
    i_st_data        = '0;
    i_st_merge_valid = 1'b0;
    i_st_merge_be    = '0;
    i_st_merge_data  = '0;
    i_perf_snap      = 1'b0;
    void'($urandom(5));
    load_trace();
    cycle_limit = n_steps * 12 + 100;
    if (n_steps == 0) begin
      $display("trace file tb/dcache_trace.txt is missing or holds no steps");
      $display("** FAIL **");
      $finish;
    end else begin
      repeat (16) @(posedge i_clk);
      i_reset_n <= 1'b1;
      for (int i = 0; i < n_steps; i++) begin
        if (i == 0 || t_name[i] != cur_name) begin
          if (i != 0) begin
            close_test();
          end
          cur_name = t_name[i];
        end
        repeat ($urandom % 4) @(posedge i_clk);   // idle gap
        run_step(i);
      end
      compare("leftover l2 requests", '0, DATA_W'(req_paddr_q.size()));
      close_test();
      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
               n_tests, n_failed, n_checks, n_errors);
      if (n_errors == 0) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: tb/dcache_trace.txt
# test op addr x mask data1 data2 exp, all hex after op; x = port, way or l2 tag
# rd exp: 1 miss, 2 hit (data1 = line), 4 conflict; st/mrsp exp: store conflict flag
miss_refill rd 1040 0 0 0 0 1
miss_refill rsp 1040 10 0 00112233445566778899aabbccddeeff 0 0
miss_refill rd 1048 0 0 00112233445566778899aabbccddeeff 0 2
miss_refill rd 7040 1 0 0 0 1
miss_refill rsp 7040 10 0 707172737475767778797a7b7c7d7e7f 0 0
miss_refill rd 7044 0 0 707172737475767778797a7b7c7d7e7f 0 2
miss_refill rd 104c 1 0 00112233445566778899aabbccddeeff 0 2
dedup_foreign rd 2050 0 0 0 0 1
dedup_foreign rd 2058 1 0 0 0 1
dedup_foreign rsp 2050 10 0 0f0e0d0c0b0a09080706050403020100 0 0
dedup_foreign rd 2050 1 0 0f0e0d0c0b0a09080706050403020100 0 2
dedup_foreign rd 3060 0 0 0 0 1
dedup_foreign rsp 0 23 0 deadbeefdeadbeefdeadbeefdeadbeef 0 0
dedup_foreign rd 3060 0 0 0 0 1
dedup_foreign rsp 3060 10 0 33333333444444445555555566666666 0 0
dedup_foreign rd 3064 1 0 33333333444444445555555566666666 0 2
perf_first snap 0 0 0 0 0 0
store_hit st 1040 0 800f a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 0 0
store_hit rd 1040 0 0 a5112233445566778899aabba5a5a5a5 0 2
store_hit rd 7040 1 0 707172737475767778797a7b7c7d7e7f 0 2
store_hit st 6090 0 ffff ffffffffffffffffffffffffffffffff 0 0
store_hit rd 6090 0 0 0 0 1
store_hit rsp 6090 10 0 0102030405060708090a0b0c0d0e0f10 0 0
store_hit rd 6090 1 0 0102030405060708090a0b0c0d0e0f10 0 2
store_merge rd 4070 0 0 0 0 1
store_merge mrsp 4070 10 00ff ffeeddccbbaa99887766554433221100 0123456789abcdef0f1e2d3c4b5a6978 1
store_merge rd 407c 1 0 ffeeddccbbaa99880f1e2d3c4b5a6978 0 2
read_conflict rd 5080 0 0 0 0 1
read_conflict rspc 5080 10 0 5a5a5a5aa5a5a5a5123456789abcdef0 0 4
read_conflict rd 5080 1 0 5a5a5a5aa5a5a5a5123456789abcdef0 0 2
perf_second snap 0 0 0 0 0 0
